// ==== source/bj_pkg.sv ====
`default_nettype none

package bj_pkg;

    // --------------------------------------------------
    // basic types
    // --------------------------------------------------
    typedef logic [3:0] rank_t;
    typedef logic [2:0] count_t;
    typedef logic [5:0] points_t;
    typedef logic [6:0] pct_t;
    typedef logic [5:0] draw_cnt_t;

    typedef enum logic
    {
        OP_CARD  = 1'b0,
        OP_JUDGE = 1'b1
    } bj_op_e;

    // encodings follow the legacy two-bit winner code
    typedef enum logic [1:0]
    {
        WIN_DRAW = 2'b00,
        WIN_P0   = 2'b10,
        WIN_P1   = 2'b11
    } winner_e;

    // --------------------------------------------------
    // shoe and scoring constants
    // --------------------------------------------------
    localparam int        NUM_RANKS        = 13;
    localparam count_t    COPIES_PER_RANK  = 3'd4;
    localparam draw_cnt_t SHOE_CARDS       = 6'd52;
    localparam draw_cnt_t SHOE_DRAWS       = 6'd50;
    localparam points_t   TARGET_POINTS    = 6'd21;
    localparam points_t   EQUAL_MIN_POINTS = 6'd11;
    localparam points_t   FACE_VALUE       = 6'd1;

    // --------------------------------------------------
    // pipeline payloads
    // --------------------------------------------------
    typedef struct packed
    {
        logic   valid;
        bj_op_e op;
        logic   player;
        logic   first;
        rank_t  rank;
    } command_t;

    typedef struct packed
    {
        logic    valid;
        bj_op_e  op;
        logic    player;
        logic    first;
        rank_t   rank;
        points_t value;
    } decoded_t;

    typedef struct packed
    {
        logic      valid;
        bj_op_e    op;
        logic      player;
        points_t   total;
        draw_cnt_t remaining;
        points_t   p0_total;
        points_t   p1_total;
    } exec_t;

    typedef struct packed
    {
        logic  valid;
        logic  player;
        pct_t  equal;
        pct_t  exceed;
    } result_t;

    // score of one rank, aces and court cards count as one
    function automatic points_t card_value(input rank_t rank);
        points_t value;
        if (rank >= 4'd2 && rank <= 4'd10)
        begin
            value = points_t'(rank);
        end
        else
        begin
            value = FACE_VALUE;
        end
        return value;
    endfunction

endpackage

`default_nettype wire

// ==== source/card_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module card_decode
    import bj_pkg::*;
(
    input  logic     clk1,
    input  logic     rst_n,
    input  command_t cmd,
    output decoded_t dec
);

    // --------------------------------------------------
    // decode register
    // --------------------------------------------------
    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            dec <= '0;
        end
        else
        begin
            dec.valid  <= cmd.valid;
            dec.op     <= cmd.op;
            dec.player <= cmd.player;
            dec.first  <= cmd.first;
            dec.rank   <= cmd.rank;
            // judge commands carry no rank, value is don't care there
            dec.value  <= card_value(cmd.rank);
        end
    end

    // rank 0 and 14..15 have no slot in the shoe
    assert property (@(posedge clk1) disable iff (!rst_n)
        (cmd.valid && cmd.op == OP_CARD)
            |-> (cmd.rank != 4'd0 && cmd.rank <= rank_t'(NUM_RANKS)));

endmodule

`default_nettype wire

// ==== source/deck_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module deck_tracker
    import bj_pkg::*;
(
    input  logic                       clk1,
    input  logic                       rst_n,
    input  decoded_t                   dec,
    output count_t [NUM_RANKS-1:0]     counts,
    output draw_cnt_t                  remaining
);

    draw_cnt_t              draw_cnt;
    draw_cnt_t              draw_next;
    logic                   card_in;
    logic                   reload;
    count_t [NUM_RANKS-1:0] shoe;

    assign card_in = dec.valid && dec.op == OP_CARD;

    // shoe is spent so this card comes from a fresh one
    assign reload = card_in && draw_cnt == SHOE_DRAWS;

    // counts the current card is taken from
    assign shoe = reload ? {NUM_RANKS{COPIES_PER_RANK}} : counts;

    // --------------------------------------------------
    // draw count after this command
    // --------------------------------------------------
    always_comb
    begin
        if (!card_in)
        begin
            draw_next = draw_cnt;
        end
        else if (reload)
        begin
            draw_next = 6'd1;
        end
        else
        begin
            draw_next = draw_cnt + 6'd1;
        end
    end

    // cards left once the current card is out
    assign remaining = SHOE_CARDS - draw_next;

    // --------------------------------------------------
    // per-rank counts
    // --------------------------------------------------
    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            counts   <= {NUM_RANKS{COPIES_PER_RANK}};
            draw_cnt <= '0;
        end
        else if (card_in)
        begin
            draw_cnt <= draw_next;
            for (int i = 0; i < NUM_RANKS; i++)
            begin
                if (dec.rank == rank_t'(i + 1))
                begin
                    counts[i] <= shoe[i] - 3'd1;
                end
                else
                begin
                    counts[i] <= shoe[i];
                end
            end
        end
    end

    // dealer side must never pick a rank that is used up
    assert property (@(posedge clk1) disable iff (!rst_n)
        card_in |-> shoe[dec.rank - 4'd1] != '0);

endmodule

`default_nettype wire

// ==== source/point_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module point_tracker
    import bj_pkg::*;
(
    input  logic      clk1,
    input  logic      rst_n,
    input  decoded_t  dec,
    input  draw_cnt_t remaining,
    output exec_t     ex
);

    points_t p0_total;
    points_t p1_total;
    points_t p0_next;
    points_t p1_next;
    points_t base;
    points_t new_total;
    logic    card_in;

    assign card_in = dec.valid && dec.op == OP_CARD;
    assign base    = dec.player ? p1_total : p0_total;

    // first card of a hand restarts the total
    assign new_total = dec.first ? dec.value : base + dec.value;

    assign p0_next = (card_in && !dec.player) ? new_total : p0_total;
    assign p1_next = (card_in && dec.player) ? new_total : p1_total;

    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            p0_total <= '0;
            p1_total <= '0;
            ex       <= '0;
        end
        else
        begin
            p0_total     <= p0_next;
            p1_total     <= p1_next;
            ex.valid     <= dec.valid;
            ex.op        <= dec.op;
            ex.player    <= dec.player;
            ex.total     <= dec.player ? p1_next : p0_next;
            ex.remaining <= remaining;
            // both hands for the judge stage
            ex.p0_total  <= p0_next;
            ex.p1_total  <= p1_next;
        end
    end

endmodule

`default_nettype wire

// ==== source/odds_calc.sv ====
`timescale 1ns/1ps
`default_nettype none

module odds_calc
    import bj_pkg::*;
(
    input  logic                   clk1,
    input  logic                   rst_n,
    input  exec_t                  ex,
    input  count_t [NUM_RANKS-1:0] counts,
    output result_t                odds
);

    points_t     gap;
    logic [5:0]  equal_cnt;
    logic [5:0]  exceed_cnt;
    logic [12:0] divisor;
    pct_t        equal_pct;
    pct_t        exceed_pct;

    // points still missing to 21, only meaningful below 21
    assign gap = TARGET_POINTS - ex.total;

    // --------------------------------------------------
    // qualifying cards
    // --------------------------------------------------
    always_comb
    begin
        equal_cnt  = '0;
        exceed_cnt = '0;

        // gap 1 picks up ranks 1/11/12/13 through their face value
        if (ex.total >= EQUAL_MIN_POINTS && ex.total < TARGET_POINTS)
        begin
            for (int i = 0; i < NUM_RANKS; i++)
            begin
                if (card_value(rank_t'(i + 1)) == gap)
                begin
                    equal_cnt = equal_cnt + 6'(counts[i]);
                end
            end
        end

        if (ex.total >= TARGET_POINTS)
        begin
            // any card at all goes over
            exceed_cnt = ex.remaining;
        end
        else if (ex.total > EQUAL_MIN_POINTS)
        begin
            for (int i = 0; i < NUM_RANKS; i++)
            begin
                if (card_value(rank_t'(i + 1)) > gap)
                begin
                    exceed_cnt = exceed_cnt + 6'(counts[i]);
                end
            end
        end
    end

    // --------------------------------------------------
    // percentages, rounded down
    // --------------------------------------------------
    assign divisor    = (ex.remaining == '0) ? 13'd1 : 13'(ex.remaining);
    assign equal_pct  = pct_t'((13'(equal_cnt) * 13'd100) / divisor);
    assign exceed_pct = pct_t'((13'(exceed_cnt) * 13'd100) / divisor);

    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            odds <= '0;
        end
        else
        begin
            odds.valid  <= ex.valid && ex.op == OP_CARD;
            odds.player <= ex.player;
            odds.equal  <= equal_pct;
            odds.exceed <= exceed_pct;
        end
    end

    // equal and exceed sets never overlap
    assert property (@(posedge clk1) disable iff (!rst_n)
        odds.valid |-> (8'(odds.equal) + 8'(odds.exceed) <= 8'd100));

endmodule

`default_nettype wire

// ==== source/winner_judge.sv ====
`timescale 1ns/1ps
`default_nettype none

module winner_judge
    import bj_pkg::*;
(
    input  logic    clk1,
    input  logic    rst_n,
    input  exec_t   ex,
    output logic    winner_valid,
    output winner_e winner
);

    logic    bust0;
    logic    bust1;
    winner_e outcome;

    assign bust0 = ex.p0_total > TARGET_POINTS;
    assign bust1 = ex.p1_total > TARGET_POINTS;

    always_comb
    begin
        if (bust0 && bust1)
        begin
            outcome = WIN_DRAW;
        end
        else if (bust1)
        begin
            outcome = WIN_P0;
        end
        else if (bust0)
        begin
            outcome = WIN_P1;
        end
        else if (ex.p0_total == ex.p1_total)
        begin
            outcome = WIN_DRAW;
        end
        else
        begin
            outcome = (ex.p0_total > ex.p1_total) ? WIN_P0 : WIN_P1;
        end
    end

    always_ff @(posedge clk1 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            winner_valid <= 1'b0;
            winner       <= WIN_DRAW;
        end
        else
        begin
            winner_valid <= ex.valid && ex.op == OP_JUDGE;
            winner       <= outcome;
        end
    end

endmodule

`default_nettype wire

// ==== source/blackjack_odds_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module blackjack_odds_top
    import bj_pkg::*;
(
    input  logic     clk1,
    input  logic     rst_n,
    input  command_t cmd,
    output result_t  odds,
    output logic     winner_valid,
    output winner_e  winner
);

    // --------------------------------------------------
    // stage wiring
    // --------------------------------------------------
    decoded_t               dec;
    exec_t                  ex;
    count_t [NUM_RANKS-1:0] counts;
    draw_cnt_t              remaining;

    card_decode i_card_decode (
        .clk1  (clk1),
        .rst_n (rst_n),
        .cmd   (cmd),
        .dec   (dec)
    );

    deck_tracker i_deck_tracker (
        .clk1      (clk1),
        .rst_n     (rst_n),
        .dec       (dec),
        .counts    (counts),
        .remaining (remaining)
    );

    point_tracker i_point_tracker (
        .clk1      (clk1),
        .rst_n     (rst_n),
        .dec       (dec),
        .remaining (remaining),
        .ex        (ex)
    );

    // result stage, both read the same exec payload
    odds_calc i_odds_calc (
        .clk1   (clk1),
        .rst_n  (rst_n),
        .ex     (ex),
        .counts (counts),
        .odds   (odds)
    );

    winner_judge i_winner_judge (
        .clk1         (clk1),
        .rst_n        (rst_n),
        .ex           (ex),
        .winner_valid (winner_valid),
        .winner       (winner)
    );

endmodule

`default_nettype wire

// ==== tests/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// --------------------------------------------------
// shoe and hand model
// --------------------------------------------------
int model_deck [1:13];
int model_draws;
int model_total [2];

task automatic refill_shoe();
    for (int r = 1; r <= NUM_RANKS; r++)
    begin
        model_deck[r] = int'(COPIES_PER_RANK);
    end
    model_draws = 0;
endtask

task automatic model_reset();
    refill_shoe();
    model_total[0] = 0;
    model_total[1] = 0;
endtask

// aces and court cards score one
function automatic int points_of(input int rank);
    return (rank >= 2 && rank <= 10) ? rank : 1;
endfunction

// a spent shoe is refilled before the next card is taken
function automatic logic rank_in_shoe(input int rank);
    return model_draws == int'(SHOE_DRAWS) || model_deck[rank] != 0;
endfunction

function automatic int equal_cards(input int total);
    int gap;
    int cnt;
    gap = int'(TARGET_POINTS) - total;
    cnt = 0;
    if (total >= int'(EQUAL_MIN_POINTS) && total < int'(TARGET_POINTS))
    begin
        cnt = (gap == 1) ? model_deck[1] + model_deck[11] + model_deck[12] + model_deck[13]
                         : model_deck[gap];
    end
    return cnt;
endfunction

function automatic int exceed_cards(input int total, input int remaining);
    int cnt;
    cnt = (total >= int'(TARGET_POINTS)) ? remaining : 0;
    for (int r = 2; r <= 10; r++)
    begin
        if (total >= 12 && total < int'(TARGET_POINTS) && r > int'(TARGET_POINTS) - total)
        begin
            cnt += model_deck[r];
        end
    end
    return cnt;
endfunction

task automatic model_card(input logic player, input logic first, input int rank,
                          input int due);
    int        remaining;
    int        total;
    odds_exp_t expected;
    if (model_draws == int'(SHOE_DRAWS))
    begin
        refill_shoe();
    end
    if (model_deck[rank] == 0)
    begin
        report_failure("testbench tried to deal a rank that is used up");
    end
    model_deck[rank]--;
    model_draws++;
    total = first ? points_of(rank) : model_total[player] + points_of(rank);
    model_total[player] = total;
    remaining = int'(SHOE_CARDS) - model_draws;
    expected.due        = due;
    expected.res.valid  = 1'b1;
    expected.res.player = player;
    expected.res.equal  = pct_t'(equal_cards(total) * 100 / remaining);
    expected.res.exceed = pct_t'(exceed_cards(total, remaining) * 100 / remaining);
    odds_q.push_back(expected);
endtask

task automatic model_judge(input int due);
    win_exp_t expected;
    logic     bust0;
    logic     bust1;
    bust0 = model_total[0] > int'(TARGET_POINTS);
    bust1 = model_total[1] > int'(TARGET_POINTS);
    expected.due = due;
    if (bust0 != bust1)
    begin
        expected.win = bust1 ? WIN_P0 : WIN_P1;
    end
    else if (bust0 || model_total[0] == model_total[1])
    begin
        expected.win = WIN_DRAW;
    end
    else
    begin
        expected.win = (model_total[0] > model_total[1]) ? WIN_P0 : WIN_P1;
    end
    win_q.push_back(expected);
endtask

`endif

// ==== tests/tb_blackjack_odds.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_blackjack_odds
    import bj_pkg::*;
();

    localparam int RESET_CYCLES = 10;
    localparam int NUM_ROUNDS   = 40;
    // directed run plus random rounds of at most 11 commands plus the refill run
    localparam int MAX_CMDS     = 20 + NUM_ROUNDS * 11 + 52;
    // room for a bubble after every command
    localparam int MAX_CYCLES   = RESET_CYCLES + 2 * MAX_CMDS + 100;

    typedef struct packed
    {
        logic [31:0] due;
        result_t     res;
    } odds_exp_t;

    typedef struct packed
    {
        logic [31:0] due;
        winner_e     win;
    } win_exp_t;

    logic      clk1;
    logic      rst_n;
    command_t  cmd;
    result_t   odds;
    logic      winner_valid;
    winner_e   winner;
    int        seed;
    int        cycle_cnt;
    odds_exp_t odds_q[$];
    win_exp_t  win_q[$];

    `include "tb_model.svh"

    blackjack_odds_top i_blackjack_odds_top (
        .clk1         (clk1),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .odds         (odds),
        .winner_valid (winner_valid),
        .winner       (winner)
    );

    always #2 clk1 = ~clk1;

    always @(posedge clk1)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES)
        begin
            report_failure("timeout, the run went past its cycle limit");
        end
    end

    // --------------------------------------------------
    // reporting and checks
    // --------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected)
        begin
            report_failure($sformatf("[ERROR] %s: got 0x%0h, expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    task automatic check_odds();
        odds_exp_t expected;
        if (odds.valid)
        begin
            if (odds_q.size() == 0 || odds_q[0].due != cycle_cnt)
            begin
                report_failure("odds.valid pulsed with no card result due in this cycle");
            end
            expected = odds_q.pop_front();
            compare_value("odds.player", 32'(odds.player), 32'(expected.res.player));
            compare_value("odds.equal", 32'(odds.equal), 32'(expected.res.equal));
            compare_value("odds.exceed", 32'(odds.exceed), 32'(expected.res.exceed));
        end
        else if (odds_q.size() != 0 && odds_q[0].due <= cycle_cnt)
        begin
            report_failure("odds.valid never came for a card command");
        end
    endtask

    task automatic check_winner();
        win_exp_t expected;
        if (winner_valid)
        begin
            if (win_q.size() == 0 || win_q[0].due != cycle_cnt)
            begin
                report_failure("winner_valid pulsed with no judge result due in this cycle");
            end
            expected = win_q.pop_front();
            compare_value("winner", 32'(winner), 32'(expected.win));
        end
        else if (win_q.size() != 0 && win_q[0].due <= cycle_cnt)
        begin
            report_failure("winner_valid never came for a judge command");
        end
    endtask

    // outputs are settled by the falling edge
    always @(negedge clk1)
    begin
        if (rst_n)
        begin
            check_odds();
            check_winner();
        end
    end

    // --------------------------------------------------
    // stimulus with one command per falling edge
    // --------------------------------------------------
    task automatic idle(input int cycles);
        repeat (cycles)
        begin
            @(negedge clk1);
            cmd = '0;
        end
    endtask

    task automatic send_card(input logic player, input logic first, input int rank);
        @(negedge clk1);
        cmd = '{1'b1, OP_CARD, player, first, rank_t'(rank)};
        model_card(player, first, rank, cycle_cnt + 3);
    endtask

    task automatic send_judge();
        @(negedge clk1);
        cmd = '{1'b1, OP_JUDGE, 1'b0, 1'b0, 4'd0};
        model_judge(cycle_cnt + 3);
    endtask

    task automatic send_random_card(input logic player, input logic first);
        int rank;
        rank = 1 + int'($unsigned($random(seed)) % NUM_RANKS);
        // step to the next rank still in the shoe
        while (!rank_in_shoe(rank))
        begin
            rank = rank % NUM_RANKS + 1;
        end
        send_card(player, first, rank);
        if ($unsigned($random(seed)) % 4 == 0)
        begin
            idle(1);
        end
    endtask

    initial
    begin
        int hand_len;
        clk1      = 1'b0;
        rst_n     = 1'b0;
        cmd       = '0;
        seed      = 32'he256;
        cycle_cnt = 0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk1);
        @(negedge clk1);
        rst_n = 1'b1;
        idle(5);

        // totals of 20 and 21 sent back to back
        send_card(1'b0, 1'b1, 10);
        send_card(1'b0, 1'b0, 10);
        send_card(1'b0, 1'b0, 12);
        send_card(1'b1, 1'b1, 7);
        send_card(1'b1, 1'b0, 7);
        send_card(1'b1, 1'b0, 7);
        // tie, p1 bust, both bust, p1 bust again, p1 ahead
        send_judge();
        send_card(1'b1, 1'b0, 5);
        send_judge();
        send_card(1'b0, 1'b1, 9);
        send_card(1'b0, 1'b0, 9);
        send_card(1'b0, 1'b0, 9);
        send_judge();
        send_card(1'b0, 1'b1, 2);
        send_card(1'b0, 1'b0, 3);
        send_judge();
        send_card(1'b1, 1'b1, 10);
        send_card(1'b1, 1'b0, 8);
        send_judge();
        idle(3);

        for (int r = 0; r < NUM_ROUNDS; r++)
        begin
            for (int p = 0; p < 2; p++)
            begin
                hand_len = 2 + int'($unsigned($random(seed)) % 4);
                for (int c = 0; c < hand_len; c++)
                begin
                    send_random_card(p[0], c == 0);
                end
            end
            send_judge();
        end

        // p1 keeps one card while p0 empties the shoe, so the
        // reload card lifts p1 into the 11..20 range
        send_random_card(1'b1, 1'b1);
        while (model_draws != int'(SHOE_DRAWS))
        begin
            send_random_card(1'b0, model_draws % 3 == 0);
        end
        send_card(1'b1, 1'b0, 10);

        while (odds_q.size() != 0 || win_q.size() != 0)
        begin
            idle(1);
        end
        // stray pulses would show up here
        idle(4);
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tests
source/bj_pkg.sv
source/card_decode.sv
source/deck_tracker.sv
source/point_tracker.sv
source/odds_calc.sv
source/winner_judge.sv
source/blackjack_odds_top.sv
tests/tb_blackjack_odds.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_blackjack_odds
FILELIST  := sources.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
